/* include/did_config.svh */
/*
  Build-time constants for the DID pipeline.
  The FIFO depth must be a power of two; register addresses must fit DID_ADDR_W.
*/
`ifndef DID_CONFIG_SVH
`define DID_CONFIG_SVH

// Data path widths in bits
`define DID_IN_W   8
`define DID_PROD_W 16
`define DID_ACC_W  24

// Entries between IAU and DPU
`define DID_FIFO_DEPTH 4

// Configuration port
`define DID_ADDR_W    4
`define DID_REG_SCALE 0
`define DID_REG_SHIFT 1
`define DID_REG_BIAS  2

`endif

/* source/did_pkg.sv */
/*
  Shared data types of the DID pipeline.
  All data words are signed two's complement, widths from did_config.svh.
*/
`include "did_config.svh"

package did_pkg;

  typedef logic signed [`DID_IN_W-1:0]   pix_t;
  typedef logic signed [`DID_PROD_W-1:0] prod_t;
  typedef logic signed [`DID_ACC_W-1:0]  acc_t;

  // DWPU to IAU beat
  typedef struct packed {
    logic  last;
    prod_t data;
  } prod_beat_t;

  // IAU to DPU beat
  typedef struct packed {
    logic last;
    acc_t data;
  } acc_beat_t;

  typedef enum logic [`DID_ADDR_W-1:0] {
    REG_SCALE = `DID_REG_SCALE,
    REG_SHIFT = `DID_REG_SHIFT,
    REG_BIAS  = `DID_REG_BIAS
  } did_reg_e;

endpackage

/* source/did_stream_if.sv */
/*
  Valid/ready stream between pipeline blocks.
  A beat moves on a clock edge with valid and ready high; the source holds
  valid, last and data stable until then.
*/
interface did_stream_if #(
  parameter type payload_t = logic
);
  logic     valid;
  logic     ready;
  logic     last;
  payload_t data;

  modport src (output valid, output last, output data, input ready);
  modport dst (input valid, input last, input data, output ready);

endinterface

/* source/did_cfg_regs.sv */
/*
  Per-stage settings written through a one-cycle strobe.
  Writes are always accepted, unmapped addresses are dropped, no read-back.
*/
`include "did_config.svh"

module did_cfg_regs (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_cfg_wr,
  input  logic [`DID_ADDR_W-1:0] i_cfg_addr,
  input  logic [15:0]            i_cfg_wdata,
  output did_pkg::pix_t          o_scale,
  output logic [2:0]             o_shift,
  output did_pkg::prod_t         o_bias
);
  import did_pkg::*;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_scale <= '0;
      o_shift <= '0;
      o_bias  <= '0;
    end else if (i_cfg_wr) begin
      case (i_cfg_addr)
        REG_SCALE: o_scale <= pix_t'(i_cfg_wdata[7:0]);
        REG_SHIFT: o_shift <= i_cfg_wdata[2:0];
        REG_BIAS:  o_bias  <= prod_t'(i_cfg_wdata);
        // Unmapped, keep everything
        default: ;
      endcase
    end
  end

endmodule

/* source/did_dwpu_stage.sv */
/*
  Depthwise scaling stage: each pixel times the signed scale.
  One output register; ready depends combinationally on downstream ready.
*/
module did_dwpu_stage (
  input  logic          i_clk,
  input  logic          i_rst_n,
  input  logic          i_pix_valid,
  input  logic          i_pix_last,
  input  did_pkg::pix_t i_pix_data,
  input  did_pkg::pix_t i_scale,
  output logic          o_pix_ready,
  output logic          o_irq,
  did_stream_if.src     dwpu_out
);
  import did_pkg::*;

  logic       out_valid;
  logic       accept;
  prod_t      product;
  prod_beat_t out_beat;

  // Register is empty or drains this cycle
  assign accept      = !out_valid || dwpu_out.ready;
  assign o_pix_ready = accept;

  // 8x8 signed always fits in 16 bits
  assign product = prod_t'(i_pix_data) * prod_t'(i_scale);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      out_valid <= 1'b0;
      o_irq     <= 1'b0;
    end else begin
      if (accept) begin
        out_valid <= i_pix_valid;
      end
      o_irq <= dwpu_out.valid && dwpu_out.ready && dwpu_out.last;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_pix_valid && accept) begin
      out_beat <= '{last: i_pix_last, data: product};
    end
  end

  assign dwpu_out.valid = out_valid;
  assign dwpu_out.last  = out_beat.last;
  assign dwpu_out.data  = out_beat;

endmodule

/* source/did_spill_reg.sv */
/*
  Two-entry skid buffer that cuts the ready path.
  Upstream ready comes straight from a flop; full throughput, order kept.
*/
module did_spill_reg #(
  parameter type payload_t = logic
) (
  input  logic      i_clk,
  input  logic      i_rst_n,
  did_stream_if.dst up,
  did_stream_if.src dn
);

  logic     a_full;
  logic     b_full;
  logic     a_fill;
  logic     a_drain;
  logic     b_fill;
  logic     b_drain;
  payload_t a_data;
  payload_t b_data;
  logic     a_last;
  logic     b_last;

  // Entry A takes new beats, B catches A when the output stalls
  assign a_fill  = up.valid && up.ready;
  assign a_drain = a_full && !b_full;
  assign b_fill  = a_drain && !dn.ready;
  assign b_drain = b_full && dn.ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      a_full <= 1'b0;
      b_full <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full <= b_fill;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (a_fill) begin
      a_data <= up.data;
      a_last <= up.last;
    end
    if (b_fill) begin
      b_data <= a_data;
      b_last <= a_last;
    end
  end

  assign up.ready = !a_full || !b_full;
  // B always holds the older beat
  assign dn.valid = a_full || b_full;
  assign dn.data  = b_full ? b_data : a_data;
  assign dn.last  = b_full ? b_last : a_last;

endmodule

/* source/did_iau_stage.sv */
/*
  Integer accumulation stage with one output register.
  The running sum restarts after every last beat; output is the new sum
  shifted right arithmetically by i_shift. Overflow wraps at 24 bits.
*/
module did_iau_stage (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic [2:0] i_shift,
  did_stream_if.dst  acc_in,
  did_stream_if.src  acc_out,
  output logic       o_irq
);
  import did_pkg::*;

  logic      out_valid;
  logic      accept;
  logic      take;
  acc_t      sum_q;
  acc_t      sum_next;
  acc_beat_t out_beat;

  assign accept   = !out_valid || acc_out.ready;
  assign take     = acc_in.valid && accept;
  assign sum_next = sum_q + acc_t'(acc_in.data.data);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      out_valid <= 1'b0;
      sum_q     <= '0;
      o_irq     <= 1'b0;
    end else begin
      if (accept) begin
        out_valid <= acc_in.valid;
      end
      if (take) begin
        // Next packet starts from zero
        sum_q <= acc_in.last ? '0 : sum_next;
      end
      o_irq <= acc_out.valid && acc_out.ready && acc_out.last;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take) begin
      out_beat <= '{last: acc_in.last, data: sum_next >>> i_shift};
    end
  end

  assign acc_in.ready  = accept;
  assign acc_out.valid = out_valid;
  assign acc_out.last  = out_beat.last;
  assign acc_out.data  = out_beat;

endmodule

/* source/did_stream_fifo.sv */
/*
  Circular-buffer FIFO with a registered output stage.
  Write to output valid takes two cycles; holds DEPTH entries plus the output
  register. Ready is low while the buffer is full.
*/
`include "did_config.svh"

module did_stream_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = `DID_FIFO_DEPTH
) (
  input  logic      i_clk,
  input  logic      i_rst_n,
  did_stream_if.dst wr,
  did_stream_if.src rd
);
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_data [DEPTH];
  logic [DEPTH-1:0] mem_last;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;
  logic             out_valid;
  logic             out_last;
  payload_t         out_data;

  assign wr.ready = (count != CNT_W'(DEPTH));
  assign push     = wr.valid && wr.ready;
  // Refill the output register when it is empty or being read
  assign pop      = (count != '0) && (!out_valid || rd.ready);

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and fill level
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      if (!out_valid || rd.ready) begin
        out_valid <= pop;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage and output register
  always_ff @(posedge i_clk) begin
    if (push) begin
      mem_data[wr_ptr] <= wr.data;
      mem_last[wr_ptr] <= wr.last;
    end
    if (pop) begin
      out_data <= mem_data[rd_ptr];
      out_last <= mem_last[rd_ptr];
    end
  end

  assign rd.valid = out_valid;
  assign rd.data  = out_data;
  assign rd.last  = out_last;

endmodule

/* source/did_dpu_stage.sv */
/*
  Output stage: accumulator plus second operand plus bias, wrapped to 24 bits.
  Takes one beat from each input together; the operand stream has no last,
  packet boundaries follow the accumulator stream.
*/
module did_dpu_stage (
  input  logic           i_clk,
  input  logic           i_rst_n,
  input  did_pkg::prod_t i_bias,
  did_stream_if.dst      dpu_in,
  input  logic           i_opd_valid,
  input  did_pkg::pix_t  i_opd_data,
  output logic           o_opd_ready,
  output logic           o_odr_valid,
  output logic           o_odr_last,
  output did_pkg::acc_t  o_odr_data,
  input  logic           i_odr_ready,
  output logic           o_irq
);
  import did_pkg::*;

  logic can_load;
  logic take;
  acc_t result;

  assign can_load = !o_odr_valid || i_odr_ready;
  // Joint transfer, each side waits for the other
  assign take         = dpu_in.valid && i_opd_valid && can_load;
  assign dpu_in.ready = i_opd_valid && can_load;
  assign o_opd_ready  = dpu_in.valid && can_load;

  assign result = dpu_in.data.data + acc_t'(i_opd_data) + acc_t'(i_bias);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_odr_valid <= 1'b0;
      o_irq       <= 1'b0;
    end else begin
      if (can_load) begin
        o_odr_valid <= dpu_in.valid && i_opd_valid;
      end
      o_irq <= o_odr_valid && i_odr_ready && o_odr_last;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take) begin
      o_odr_last <= dpu_in.last;
      o_odr_data <= result;
    end
  end

endmodule

/* source/did_top.sv */
/*
  DID pipeline: DWPU, skid buffer, IAU, FIFO, DPU.
  Latency from input to output varies with back-pressure; order is kept.
  o_irq bits 0..2 pulse for DWPU, IAU and DPU packet ends.
*/
`include "did_config.svh"

module did_top (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_cfg_wr,
  input  logic [`DID_ADDR_W-1:0] i_cfg_addr,
  input  logic [15:0]            i_cfg_wdata,
  // First input stream, into DWPU
  input  logic                   i_ifd0_valid,
  input  logic                   i_ifd0_last,
  input  did_pkg::pix_t          i_ifd0_data,
  output logic                   o_ifd0_ready,
  // Second input stream, into DPU
  input  logic                   i_ifd1_valid,
  input  did_pkg::pix_t          i_ifd1_data,
  output logic                   o_ifd1_ready,
  // Output stream
  output logic                   o_odr_valid,
  output logic                   o_odr_last,
  output did_pkg::acc_t          o_odr_data,
  input  logic                   i_odr_ready,
  output logic [2:0]             o_irq
);
  import did_pkg::*;

  pix_t       scale;
  logic [2:0] shift;
  prod_t      bias;

  did_stream_if #(.payload_t(prod_beat_t)) dwpu_if ();
  did_stream_if #(.payload_t(prod_beat_t)) iau_in_if ();
  did_stream_if #(.payload_t(acc_beat_t))  iau_out_if ();
  did_stream_if #(.payload_t(acc_beat_t))  dpu_in_if ();

  ////////////////////////////////////////////////////////////////////////////
  // Configuration
  did_cfg_regs u_cfg_regs (
    .i_clk,
    .i_rst_n,
    .i_cfg_wr,
    .i_cfg_addr,
    .i_cfg_wdata,
    .o_scale (scale),
    .o_shift (shift),
    .o_bias  (bias)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Compute chain
  did_dwpu_stage u_dwpu (
    .i_clk,
    .i_rst_n,
    .i_pix_valid (i_ifd0_valid),
    .i_pix_last  (i_ifd0_last),
    .i_pix_data  (i_ifd0_data),
    .i_scale     (scale),
    .o_pix_ready (o_ifd0_ready),
    .o_irq       (o_irq[0]),
    .dwpu_out    (dwpu_if)
  );

  did_spill_reg #(.payload_t(prod_beat_t)) u_spill_reg (
    .i_clk,
    .i_rst_n,
    .up (dwpu_if),
    .dn (iau_in_if)
  );

  did_iau_stage u_iau (
    .i_clk,
    .i_rst_n,
    .i_shift (shift),
    .acc_in  (iau_in_if),
    .acc_out (iau_out_if),
    .o_irq   (o_irq[1])
  );

  did_stream_fifo #(.payload_t(acc_beat_t)) u_fifo (
    .i_clk,
    .i_rst_n,
    .wr (iau_out_if),
    .rd (dpu_in_if)
  );

  did_dpu_stage u_dpu (
    .i_clk,
    .i_rst_n,
    .i_bias      (bias),
    .dpu_in      (dpu_in_if),
    .i_opd_valid (i_ifd1_valid),
    .i_opd_data  (i_ifd1_data),
    .o_opd_ready (o_ifd1_ready),
    .o_odr_valid,
    .o_odr_last,
    .o_odr_data,
    .i_odr_ready,
    .o_irq       (o_irq[2])
  );

endmodule

/* test/tb_did_top.sv */
/*
  Table-driven testbench for did_top.
  Expected results come from a software model of the pipeline rules.
  Configuration is only written while the pipeline is idle.
*/
`include "did_config.svh"

module tb_did_top;
  timeunit 1ns;
  timeprecision 1ps;
  import did_pkg::*;

  localparam int N_CASES = 6;
  localparam int MAX_LEN = 6;
  localparam int TIMEOUT = 200;

  ////////////////////////////////////////////////////////////////////////////
  // Case table of configuration, packet shape, back-pressure and unmapped write
  int c_scale [N_CASES] = '{1, -3, 127, 127, -128, 2};
  int c_shift [N_CASES] = '{0, 2, 5, 5, 7, 1};
  int c_bias  [N_CASES] = '{0, -100, 1000, 1000, -32768, 5};
  int c_len   [N_CASES] = '{3, 6, 5, 5, 6, 1};
  int c_npkt  [N_CASES] = '{2, 2, 3, 2, 4, 3};
  bit c_bp    [N_CASES] = '{0, 0, 1, 0, 1, 1};
  bit c_junk  [N_CASES] = '{0, 0, 0, 1, 0, 0};
  int c_pix [N_CASES][MAX_LEN] = '{
    '{1, 2, 3, 4, 5, 6},
    '{-7, 12, -128, 127, 0, 33},
    '{100, -100, 50, 127, -1, 9},
    '{100, -100, 50, 127, -1, 9},
    '{-128, -128, -128, 127, 127, -3},
    '{-5, 17, 64, -64, 0, 1}
  };
  int c_opd [N_CASES][MAX_LEN] = '{
    '{0, 0, 0, 0, 0, 0},
    '{10, -20, 30, -40, 50, -60},
    '{-128, 127, 0, 1, -1, 64},
    '{-128, 127, 0, 1, -1, 64},
    '{127, 127, -128, -128, 3, -3},
    '{7, -7, 100, -100, 0, 2}
  };

  logic                   i_clk = 1'b0;
  logic                   i_rst_n;
  logic                   i_cfg_wr;
  logic [`DID_ADDR_W-1:0] i_cfg_addr;
  logic [15:0]            i_cfg_wdata;
  logic                   i_ifd0_valid;
  logic                   i_ifd0_last;
  pix_t                   i_ifd0_data;
  logic                   o_ifd0_ready;
  logic                   i_ifd1_valid;
  pix_t                   i_ifd1_data;
  logic                   o_ifd1_ready;
  logic                   o_odr_valid;
  logic                   o_odr_last;
  acc_t                   o_odr_data;
  logic                   i_odr_ready;
  logic [2:0]             o_irq;

  int   mismatch_cnt = 0;
  int   timeout_cnt  = 0;
  int   irq_cnt [3]  = '{0, 0, 0};
  int   pkt_total    = 0;
  bit   case_done;
  acc_t exp_data_q [$];
  bit   exp_last_q [$];

  did_top u_did_top (.*);

  always #2 i_clk = ~i_clk;

  // One pulse per packet per stage
  always @(negedge i_clk) begin
    if (i_rst_n) begin
      for (int b = 0; b < 3; b++) begin
        if (o_irq[b]) begin
          irq_cnt[b]++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  function automatic bit beat_ready(input int port);
    case (port)
      0:       return o_ifd0_ready;
      1:       return o_ifd1_ready;
      default: return o_odr_valid && i_odr_ready;
    endcase
  endfunction

  // Ready seen at the falling edge holds through the next rising edge
  task automatic wait_beat(input int port, output bit ok);
    int t;
    t = 0;
    do begin
      @(negedge i_clk);
      t++;
    end while (!beat_ready(port) && t < TIMEOUT);
    ok = beat_ready(port);
    if (!ok) begin
      $display("%0t: timeout, no transfer on stream %0d after %0d cycles", $time, port, t);
      timeout_cnt++;
    end
  endtask

  task automatic write_cfg(input logic [`DID_ADDR_W-1:0] addr, input logic [15:0] data);
    i_cfg_wr    = 1'b1;
    i_cfg_addr  = addr;
    i_cfg_wdata = data;
    @(posedge i_clk);
    #1;
    i_cfg_wr = 1'b0;
  endtask

  // Sum wraps at 24 bits and restarts per packet
  task automatic build_expected(input int c);
    logic signed [23:0] sum;
    logic signed [23:0] res;
    int                 idx;
    for (int p = 0; p < c_npkt[c]; p++) begin
      sum = '0;
      for (int i = 0; i < c_len[c]; i++) begin
        idx = (i + p) % MAX_LEN;
        sum = sum + c_pix[c][idx] * c_scale[c];
        res = (sum >>> c_shift[c]) + c_opd[c][idx] + c_bias[c];
        exp_data_q.push_back(res);
        exp_last_q.push_back(i == c_len[c] - 1);
      end
    end
  endtask

  task automatic send_pix(input int c);
    bit ok;
    for (int p = 0; p < c_npkt[c]; p++) begin
      for (int i = 0; i < c_len[c]; i++) begin
        i_ifd0_valid = 1'b1;
        i_ifd0_last  = (i == c_len[c] - 1);
        i_ifd0_data  = pix_t'(c_pix[c][(i + p) % MAX_LEN]);
        wait_beat(0, ok);
        if (!ok) begin
          i_ifd0_valid = 1'b0;
          return;
        end
        @(posedge i_clk);
        #1;
      end
    end
    i_ifd0_valid = 1'b0;
  endtask

  task automatic send_opd(input int c);
    bit ok;
    for (int p = 0; p < c_npkt[c]; p++) begin
      for (int i = 0; i < c_len[c]; i++) begin
        i_ifd1_valid = 1'b1;
        i_ifd1_data  = pix_t'(c_opd[c][(i + p) % MAX_LEN]);
        wait_beat(1, ok);
        if (!ok) begin
          i_ifd1_valid = 1'b0;
          return;
        end
        @(posedge i_clk);
        #1;
      end
    end
    i_ifd1_valid = 1'b0;
  endtask

  task automatic collect(input int n);
    bit   ok;
    acc_t exp_data;
    bit   exp_last;
    for (int k = 0; k < n; k++) begin
      wait_beat(2, ok);
      if (!ok) begin
        return;
      end
      exp_data = exp_data_q.pop_front();
      exp_last = exp_last_q.pop_front();
      assert (o_odr_data === exp_data) else begin
        $display("Mismatch at %0t: o_odr_data got %0d expected %0d",
                 $time, o_odr_data, exp_data);
        mismatch_cnt++;
      end
      assert (o_odr_last === exp_last) else begin
        $display("Mismatch at %0t: o_odr_last got %0b expected %0b",
                 $time, o_odr_last, exp_last);
        mismatch_cnt++;
      end
      @(posedge i_clk);
    end
  endtask

  task automatic drive_odr_ready(input bit bp);
    int t;
    t = 0;
    while (!case_done && t < TIMEOUT * 64) begin
      i_odr_ready = bp ? 1'($urandom_range(1, 0)) : 1'b1;
      @(posedge i_clk);
      #1;
      t++;
    end
    if (!case_done) begin
      $display("%0t: timeout, output collection never finished", $time);
      timeout_cnt++;
    end
  endtask

  task automatic run_case(input int c);
    write_cfg(`DID_REG_SCALE, 16'(c_scale[c]));
    write_cfg(`DID_REG_SHIFT, 16'(c_shift[c]));
    write_cfg(`DID_REG_BIAS, 16'(c_bias[c]));
    if (c_junk[c]) begin
      write_cfg(4'h3, 16'hffff);
      write_cfg(4'h4, 16'h8001);
    end
    exp_data_q.delete();
    exp_last_q.delete();
    build_expected(c);
    pkt_total += c_npkt[c];
    case_done = 1'b0;
    fork
      send_pix(c);
      send_opd(c);
      drive_odr_ready(c_bp[c]);
      begin
        collect(c_npkt[c] * c_len[c]);
        case_done = 1'b1;
      end
    join
    i_odr_ready = 1'b1;
    // Room for the last interrupt pulses
    repeat (3) @(posedge i_clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  initial begin
    void'($urandom(32'hd737));
    i_rst_n      = 1'b0;
    i_cfg_wr     = 1'b0;
    i_cfg_addr   = '0;
    i_cfg_wdata  = '0;
    i_ifd0_valid = 1'b0;
    i_ifd0_last  = 1'b0;
    i_ifd0_data  = '0;
    i_ifd1_valid = 1'b0;
    i_ifd1_data  = '0;
    i_odr_ready  = 1'b1;
    repeat (5) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    // Quiet outputs before any input
    repeat (4) begin
      @(negedge i_clk);
      assert (o_odr_valid === 1'b0) else begin
        $display("Mismatch at %0t: o_odr_valid got %0b expected 0", $time, o_odr_valid);
        mismatch_cnt++;
      end
      assert (o_irq === 3'b000) else begin
        $display("Mismatch at %0t: o_irq got %b expected 000", $time, o_irq);
        mismatch_cnt++;
      end
    end
    @(posedge i_clk);
    #1;
    for (int c = 0; c < N_CASES; c++) begin
      run_case(c);
    end
    for (int b = 0; b < 3; b++) begin
      assert (irq_cnt[b] == pkt_total) else begin
        $display("Mismatch at %0t: o_irq[%0d] pulse count got %0d expected %0d",
                 $time, b, irq_cnt[b], pkt_total);
        mismatch_cnt++;
      end
    end
    $display("Errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+include
source/did_pkg.sv
source/did_stream_if.sv
source/did_cfg_regs.sv
source/did_dwpu_stage.sv
source/did_spill_reg.sv
source/did_iau_stage.sv
source/did_stream_fifo.sv
source/did_dpu_stage.sv
source/did_top.sv
test/tb_did_top.sv

/* Bender.yml */
package:
  name: did

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/did_pkg.sv
      - source/did_stream_if.sv
      - source/did_cfg_regs.sv
      - source/did_dwpu_stage.sv
      - source/did_spill_reg.sv
      - source/did_iau_stage.sv
      - source/did_stream_fifo.sv
      - source/did_dpu_stage.sv
      - source/did_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_did_top.sv
